//--- project.f
+incdir+.
ping_timer_pkg.sv
ping_lfsr.sv
ping_sequencer.sv
ping_request_gen.sv
ping_timer_top.sv
ping_timer_checker.sv
ping_timer_tb.sv

//--- Makefile
SIM     ?= verilator
TOP     ?= ping_timer_tb
FLIST   ?= project.f
VFLAGS  ?= --binary --timing --assert --timescale 1ns/10ps
RUNARGS ?= +verilator+error+limit+1000
FAIL_MSG := Simulation finished: FAIL
PASS_MSG := Simulation finished: PASS

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
LOG     := sim.log
SRCS    := $(shell grep -v '^+' $(FLIST)) ping_timer_config.svh

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) $(RUNARGS) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- ping_timer_tb.sv
/*
 * ping timer testbench
 * runs the timer through responsive, silent, sparse-mask and spurious-ok
 * phases while assertions here and in the bound checker watch the ports
 */
`timescale 1ns/10ps
`include "ping_timer_config.svh"

module ping_timer_tb import ping_timer_pkg::*; ();

  localparam int     TIMEOUT     = 12;
  localparam int     PINGS       = 40;
  localparam int     PH_IDLE     = 0;
  localparam int     PH_RESP     = 1;
  localparam int     PH_SILENT   = 2;
  localparam int     PH_SPARSE   = 3;
  localparam int     PH_SPUR     = 4;
  localparam longint WATCHDOG_NS = 4 * PINGS * (255 + TIMEOUT + 2) * 10 + 20000;

  logic       clk_i = 1'b0;
  logic       rst_ni = 1'b0;
  logic       en_i = 1'b0;
  alert_vec_t alert_en_i = '1;
  cnt_t       timeout_cyc_i = cnt_t'(TIMEOUT);
  alert_vec_t alert_ok_i = '0;
  esc_vec_t   esc_ok_i = '0;
  alert_vec_t alert_ping_req_o;
  esc_vec_t   esc_ping_req_o;
  logic       alert_fail_o;
  logic       esc_fail_o;

  int          phase = PH_IDLE;
  int          err_cnt = 0;
  int          misc_err = 0;
  int          hold_cnt = 0;
  int          alert_pings = 0;
  int          esc_pings = 0;
  logic        alert_any_q = 1'b0;
  logic        esc_any_q = 1'b0;
  logic        busy = 1'b0;
  logic        acked = 1'b0;
  int          delay_left = 0;
  alert_vec_t  inj_alert = '0;
  esc_vec_t    inj_esc = '0;
  logic [31:0] lcg_state = 32'hd4a364f9;
  logic        req_any;

  assign req_any = |alert_ping_req_o || |esc_ping_req_o;

  always #5 clk_i = ~clk_i;

  ping_timer_top i_ping_timer_top (.*);

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int total_errors();
    return err_cnt + misc_err + int'(i_ping_timer_top.i_checker.fail_cnt);
  endfunction

  //////////////////////////////////////////////////
  // monitors and responder models
  //////////////////////////////////////////////////

  // hold_cnt is the number of earlier cycles of the current request
  always @(posedge clk_i) begin
    alert_any_q <= |alert_ping_req_o;
    esc_any_q   <= |esc_ping_req_o;
    hold_cnt    <= req_any ? hold_cnt + 1 : 0;
    if (|alert_ping_req_o && !alert_any_q) alert_pings <= alert_pings + 1;
    if (|esc_ping_req_o && !esc_any_q) esc_pings <= esc_pings + 1;
  end

  // answers each ping once after a random delay, or replays injected oks
  always @(posedge clk_i) begin
    if (!rst_ni || phase == PH_IDLE || phase == PH_SILENT) begin
      busy       <= 1'b0;
      acked      <= 1'b0;
      alert_ok_i <= '0;
      esc_ok_i   <= '0;
    end else if (phase == PH_SPUR) begin
      alert_ok_i <= inj_alert;
      esc_ok_i   <= inj_esc;
    end else if (!req_any) begin
      busy       <= 1'b0;
      acked      <= 1'b0;
      alert_ok_i <= '0;
      esc_ok_i   <= '0;
    end else if (!busy) begin
      busy       <= 1'b1;
      delay_left <= int'(lcg_next() >> 16) % 6;
    end else if (acked) begin
      alert_ok_i <= '0;
      esc_ok_i   <= '0;
    end else if (delay_left == 0) begin
      alert_ok_i <= alert_ping_req_o;
      esc_ok_i   <= esc_ping_req_o;
      acked      <= 1'b1;
    end else begin
      delay_left <= delay_left - 1;
    end
  end

  //////////////////////////////////////////////////
  // phase assertions
  //////////////////////////////////////////////////

  a_no_fail: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (phase == PH_RESP || phase == PH_SPARSE) |-> !(alert_fail_o || esc_fail_o))
    else begin
      $display("[FAIL] %0t alert_fail_o,esc_fail_o got %b%b expected 00", $time,
               $sampled(alert_fail_o), $sampled(esc_fail_o));
      err_cnt++;
    end

  // in the first cycle after the drop, hold_cnt still holds the full request length
  a_silent_len: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (phase == PH_SILENT && $fell(req_any)) |-> (hold_cnt == TIMEOUT + 1))
    else begin
      $display("[FAIL] %0t req_any length got %0d expected %0d", $time,
               $sampled(hold_cnt), TIMEOUT + 1);
      err_cnt++;
    end

  a_silent_fail_last: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (phase == PH_SILENT && req_any && hold_cnt == TIMEOUT) |->
    (alert_fail_o == |alert_ping_req_o && esc_fail_o == |esc_ping_req_o))
    else begin
      $display("[FAIL] %0t alert_fail_o,esc_fail_o in last cycle got %b%b expected %b%b",
               $time, $sampled(alert_fail_o), $sampled(esc_fail_o),
               $sampled(|alert_ping_req_o), $sampled(|esc_ping_req_o));
      err_cnt++;
    end

  a_silent_fail_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (phase == PH_SILENT && (alert_fail_o || esc_fail_o)) |-> (req_any && hold_cnt == TIMEOUT))
    else begin
      $display("[FAIL] %0t hold_cnt at fail got %0d expected %0d", $time,
               $sampled(hold_cnt), TIMEOUT);
      err_cnt++;
    end

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  task automatic run_pings(input int n);
    int target;
    target = alert_pings + esc_pings + n;
    while (alert_pings + esc_pings < target) @(negedge clk_i);
  endtask

  // phases only change between pings
  task automatic switch_phase(input int next);
    @(negedge clk_i);
    while (req_any) @(negedge clk_i);
    @(posedge clk_i);
    phase <= next;
  endtask

  task automatic inject_spurious(input int n);
    for (int i = 0; i < n; i++) begin
      @(negedge clk_i);
      while (req_any) @(negedge clk_i);
      @(posedge clk_i);
      if (i % 2 == 0) inj_alert <= alert_vec_t'(1) << (i % `PT_N_ALERTS);
      else inj_esc <= esc_vec_t'(1) << (i % `PT_N_ESC);
      @(posedge clk_i);
      inj_alert <= '0;
      inj_esc   <= '0;
      repeat (3) @(posedge clk_i);
    end
  endtask

  task automatic report_phase(input string name);
    $display("phase %s finished: %0d pings, %0d errors so far",
             name, alert_pings + esc_pings, total_errors());
  endtask

  initial begin
    int esc_start;
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    // requests must stay low while en_i is still off
    repeat (20) @(posedge clk_i);
    report_phase("before enable");
    en_i  <= 1'b1;
    phase <= PH_RESP;
    run_pings(PINGS);
    report_phase("responsive");
    switch_phase(PH_SILENT);
    run_pings(PINGS);
    report_phase("silent");
    switch_phase(PH_SPARSE);
    alert_en_i <= 6'b100100;
    esc_start = esc_pings;
    run_pings(PINGS);
    if (esc_pings == esc_start) begin
      $display("escalation pings stopped under the sparse alert mask");
      misc_err++;
    end
    report_phase("sparse mask");
    switch_phase(PH_SPUR);
    alert_en_i <= '1;
    inject_spurious(8);
    report_phase("spurious ok");
    $display("summary: 5 phases, %0d pings, %0d testbench errors, %0d checker errors",
             alert_pings + esc_pings, err_cnt + misc_err, i_ping_timer_top.i_checker.fail_cnt);
    if (total_errors() == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the phases completed");
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

//--- ping_timer_checker.sv
/*
 * ping timer checker
 * concurrent assertions on the ports of the alert ping timer top level,
 * attached to every instance of it with bind
 */
`timescale 1ns/10ps

module ping_timer_checker import ping_timer_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  alert_vec_t alert_en_i,
  input  alert_vec_t alert_ok_i,
  input  esc_vec_t   esc_ok_i,
  input  alert_vec_t alert_ping_req_o,
  input  esc_vec_t   esc_ping_req_o,
  input  logic       alert_fail_o,
  input  logic       esc_fail_o
);

  logic    en_seen_q;
  logic    alert_any_q;
  logic    esc_any_q;
  logic    alert_pending_q;
  esc_id_t esc_exp_q;
  logic    alert_rise;
  logic    esc_rise;

  // number of failed assertions, read by the testbench at the end
  int unsigned fail_cnt = 0;

  assign alert_rise = |alert_ping_req_o && !alert_any_q;
  assign esc_rise   = |esc_ping_req_o && !esc_any_q;

  //////////////////////////////////////////////////
  // reference state for ordering
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      en_seen_q       <= 1'b0;
      alert_any_q     <= 1'b0;
      esc_any_q       <= 1'b0;
      alert_pending_q <= 1'b0;
      esc_exp_q       <= '0;
    end else begin
      en_seen_q   <= en_seen_q | en_i;
      alert_any_q <= |alert_ping_req_o;
      esc_any_q   <= |esc_ping_req_o;
      // an alert check opens a round that the next escalation ping closes
      if (alert_rise) begin
        alert_pending_q <= 1'b1;
      end else if (esc_rise) begin
        alert_pending_q <= 1'b0;
      end
      // escalation channels go round robin, wrapping after the last one
      if (esc_rise) begin
        esc_exp_q <= esc_exp_q + 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////
  // assertions
  //////////////////////////////////////////////////

  a_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({alert_ping_req_o, esc_ping_req_o}))
    else begin $error("more than one ping request high"); fail_cnt++; end

  a_quiet_before_en: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !en_seen_q |-> (alert_ping_req_o == '0 && esc_ping_req_o == '0))
    else begin $error("ping request before the first enable"); fail_cnt++; end

  // an answered request is gone in the following cycle
  a_alert_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(alert_ok_i & alert_ping_req_o) |=> (alert_ping_req_o == '0))
    else begin $error("alert request held after its answer"); fail_cnt++; end

  a_esc_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(esc_ok_i & esc_ping_req_o) |=> (esc_ping_req_o == '0))
    else begin $error("escalation request held after its answer"); fail_cnt++; end

  a_esc_order: assert property (@(posedge clk_i) disable iff (!rst_ni)
    esc_rise |-> (esc_ping_req_o == (esc_vec_t'(1) << esc_exp_q)))
    else begin $error("escalation channel out of round-robin order"); fail_cnt++; end

  a_alternate: assert property (@(posedge clk_i) disable iff (!rst_ni)
    alert_rise |-> !alert_pending_q)
    else begin $error("two alert checks without an escalation check"); fail_cnt++; end

  a_enabled_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (alert_ping_req_o & ~alert_en_i) == '0)
    else begin $error("ping request to a disabled alert"); fail_cnt++; end

  // an ok without its own request must show up on the fail output at once
  a_spur_alert: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(alert_ok_i & ~alert_ping_req_o) |-> alert_fail_o)
    else begin $error("spurious alert ok not flagged"); fail_cnt++; end

  a_spur_esc: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |(esc_ok_i & ~esc_ping_req_o) |-> esc_fail_o)
    else begin $error("spurious escalation ok not flagged"); fail_cnt++; end

endmodule

bind ping_timer_top ping_timer_checker i_checker (.*);

//--- ping_timer_top.sv
/*
 * alert ping timer top
 * connects the LFSR, the ping sequencer and the request generator
 */
`timescale 1ns/10ps

module ping_timer_top import ping_timer_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       en_i,
  input  alert_vec_t alert_en_i,
  input  cnt_t       timeout_cyc_i,
  input  alert_vec_t alert_ok_i,
  input  esc_vec_t   esc_ok_i,
  output alert_vec_t alert_ping_req_o,
  output esc_vec_t   esc_ping_req_o,
  output logic       alert_fail_o,
  output logic       esc_fail_o
);

  // sequencer to LFSR and request generator
  logic      draw;
  logic      alert_ping_en;
  logic      esc_ping_en;
  logic      esc_advance;
  logic      alert_timeout;
  logic      esc_timeout;
  // LFSR outputs
  alert_id_t next_id;
  cnt_t      wait_cyc;
  // request generator back to the sequencer
  logic      id_valid;
  logic      alert_answered;
  logic      esc_answered;

  ping_lfsr i_lfsr (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .draw_i     (draw),
    .next_id_o  (next_id),
    .wait_cyc_o (wait_cyc)
  );

  ping_sequencer i_sequencer (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .en_i             (en_i),
    .timeout_cyc_i    (timeout_cyc_i),
    .wait_cyc_i       (wait_cyc),
    .id_valid_i       (id_valid),
    .alert_answered_i (alert_answered),
    .esc_answered_i   (esc_answered),
    .draw_o           (draw),
    .alert_ping_en_o  (alert_ping_en),
    .esc_ping_en_o    (esc_ping_en),
    .esc_advance_o    (esc_advance),
    .alert_timeout_o  (alert_timeout),
    .esc_timeout_o    (esc_timeout)
  );

  ping_request_gen i_request_gen (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .draw_i           (draw),
    .next_id_i        (next_id),
    .esc_advance_i    (esc_advance),
    .alert_ping_en_i  (alert_ping_en),
    .esc_ping_en_i    (esc_ping_en),
    .alert_timeout_i  (alert_timeout),
    .esc_timeout_i    (esc_timeout),
    .alert_en_i       (alert_en_i),
    .alert_ok_i       (alert_ok_i),
    .esc_ok_i         (esc_ok_i),
    .alert_ping_req_o (alert_ping_req_o),
    .esc_ping_req_o   (esc_ping_req_o),
    .id_valid_o       (id_valid),
    .alert_answered_o (alert_answered),
    .esc_answered_o   (esc_answered),
    .alert_fail_o     (alert_fail_o),
    .esc_fail_o       (esc_fail_o)
  );

endmodule

//--- ping_request_gen.sv
/*
 * ping request generator
 * holds the alert and escalation indices, decodes the one-hot requests
 * and sorts the ok inputs into answers and spurious responses
 */
`timescale 1ns/10ps
`include "ping_timer_config.svh"

module ping_request_gen import ping_timer_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       draw_i,
  input  alert_id_t  next_id_i,
  input  logic       esc_advance_i,
  input  logic       alert_ping_en_i,
  input  logic       esc_ping_en_i,
  input  logic       alert_timeout_i,
  input  logic       esc_timeout_i,
  input  alert_vec_t alert_en_i,
  input  alert_vec_t alert_ok_i,
  input  esc_vec_t   esc_ok_i,
  output alert_vec_t alert_ping_req_o,
  output esc_vec_t   esc_ping_req_o,
  output logic       id_valid_o,
  output logic       alert_answered_o,
  output logic       esc_answered_o,
  output logic       alert_fail_o,
  output logic       esc_fail_o
);

  alert_id_t                 alert_id_q;
  esc_id_t                   esc_id_q;
  logic [2**`PT_ID_DW-1:0]   en_mask;
  logic                      spurious_alert;
  logic                      spurious_esc;

  //////////////////////////////////////////////////
  // index registers
  //////////////////////////////////////////////////

  // the index must stay fixed for the whole ping, or the answer looks spurious
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alert_id_q <= '0;
      esc_id_q   <= '0;
    end else begin
      if (draw_i) begin
        alert_id_q <= next_id_i;
      end
      if (esc_advance_i) begin
        esc_id_q <= (esc_id_q == esc_id_t'(`PT_N_ESC - 1)) ? '0 : esc_id_q + 1'b1;
      end
    end
  end

  // pad the enables to a power of two so every index value selects a bit
  assign en_mask    = (2**`PT_ID_DW)'(alert_en_i);
  assign id_valid_o = en_mask[alert_id_q];

  //////////////////////////////////////////////////
  // requests and responses
  //////////////////////////////////////////////////

  assign alert_ping_req_o = alert_vec_t'(alert_ping_en_i) << alert_id_q;
  assign esc_ping_req_o   = esc_vec_t'(esc_ping_en_i) << esc_id_q;

  assign alert_answered_o = |(alert_ok_i & alert_ping_req_o);
  assign esc_answered_o   = |(esc_ok_i & esc_ping_req_o);

  // any ok without its own request counts, late answers included
  assign spurious_alert = |(alert_ok_i & ~alert_ping_req_o);
  assign spurious_esc   = |(esc_ok_i & ~esc_ping_req_o);

  assign alert_fail_o = spurious_alert | alert_timeout_i;
  assign esc_fail_o   = spurious_esc | esc_timeout_i;

endmodule

//--- ping_sequencer.sv
/*
 * ping sequencer
 * FSM that alternates alert and escalation checks, each a random pause
 * followed by a ping that ends on an answer, a timeout or a skip
 */
`timescale 1ns/10ps

module ping_sequencer import ping_timer_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic en_i,
  input  cnt_t timeout_cyc_i,
  input  cnt_t wait_cyc_i,
  input  logic id_valid_i,
  input  logic alert_answered_i,
  input  logic esc_answered_i,
  output logic draw_o,
  output logic alert_ping_en_o,
  output logic esc_ping_en_o,
  output logic esc_advance_o,
  output logic alert_timeout_o,
  output logic esc_timeout_o
);

  state_e state_q;
  state_e state_d;
  cnt_t   cnt_q;
  cnt_t   cnt_setval;
  check_e check_kind;
  logic   wait_set;
  logic   timeout_set;
  logic   timer_expired;
  logic   ping_timeout;

  //////////////////////////////////////////////////
  // shared down-counter
  //////////////////////////////////////////////////

  // a value W loaded here runs for W+1 cycles before it reads zero
  assign timer_expired = (cnt_q == '0);
  assign cnt_setval    = wait_set ? wait_cyc_i : timeout_cyc_i;

  // every load also pulls a fresh value from the LFSR
  assign draw_o = wait_set | timeout_set;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (draw_o) begin
      cnt_q <= cnt_setval;
    end else if (!timer_expired) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // ping FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d         = state_q;
    wait_set        = 1'b0;
    timeout_set     = 1'b0;
    alert_ping_en_o = 1'b0;
    esc_ping_en_o   = 1'b0;
    esc_advance_o   = 1'b0;
    ping_timeout    = 1'b0;

    unique case (state_q)
      // leaves on the first enable and is never entered again
      INIT: begin
        if (en_i) begin
          state_d  = ALERT_WAIT;
          wait_set = 1'b1;
        end
      end
      ALERT_WAIT: begin
        if (timer_expired) begin
          state_d     = ALERT_PING;
          timeout_set = 1'b1;
        end
      end
      // a disabled index skips the check after one cycle without a request
      ALERT_PING: begin
        alert_ping_en_o = id_valid_i;
        if (timer_expired || alert_answered_i || !id_valid_i) begin
          state_d      = ESC_WAIT;
          wait_set     = 1'b1;
          ping_timeout = timer_expired && id_valid_i && !alert_answered_i;
        end
      end
      ESC_WAIT: begin
        if (timer_expired) begin
          state_d     = ESC_PING;
          timeout_set = 1'b1;
        end
      end
      // the round-robin index steps when the check ends, pass or fail
      ESC_PING: begin
        esc_ping_en_o = 1'b1;
        if (timer_expired || esc_answered_i) begin
          state_d       = ALERT_WAIT;
          wait_set      = 1'b1;
          esc_advance_o = 1'b1;
          ping_timeout  = timer_expired && !esc_answered_i;
        end
      end
      default: begin
        state_d = INIT;
      end
    endcase
  end

  // steer the timeout pulse to the side whose check is running
  assign check_kind = (state_q == ESC_WAIT || state_q == ESC_PING) ? CHECK_ESC : CHECK_ALERT;

  assign alert_timeout_o = ping_timeout && (check_kind == CHECK_ALERT);
  assign esc_timeout_o   = ping_timeout && (check_kind == CHECK_ESC);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= INIT;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- ping_lfsr.sv
/*
 * ping LFSR
 * 16-bit Galois LFSR stepped once per draw, presenting a folded alert
 * index from its upper bits and a pause length from its lower bits
 */
`timescale 1ns/10ps
`include "ping_timer_config.svh"

module ping_lfsr import ping_timer_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      draw_i,
  output alert_id_t next_id_o,
  output cnt_t      wait_cyc_o
);

  logic [`PT_LFSR_DW-1:0] lfsr_q;
  logic [`PT_LFSR_DW-1:0] lfsr_d;
  alert_id_t              raw_id;

  //////////////////////////////////////////////////
  // LFSR state
  //////////////////////////////////////////////////

  // right-shifting Galois form, the bit shifted out selects the tap mask
  assign lfsr_d = (lfsr_q >> 1) ^ (lfsr_q[0] ? `PT_LFSR_TAPS : '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `PT_LFSR_SEED;
    end else if (draw_i) begin
      // the consumers sample the current outputs in the draw cycle
      lfsr_q <= lfsr_d;
    end
  end

  //////////////////////////////////////////////////
  // derived values
  //////////////////////////////////////////////////

  // index from the top bits of the state
  assign raw_id = lfsr_q[`PT_LFSR_DW-1 -: `PT_ID_DW];

  // out of range indices are folded back down, so the lowest indices come up
  // more often but fewer draws end up as skips
  assign next_id_o = (raw_id >= alert_id_t'(`PT_N_ALERTS)) ?
                     raw_id - alert_id_t'(`PT_N_ALERTS) : raw_id;

  // pause from the low bits, with the minimum pause bit always set
  assign wait_cyc_o = lfsr_q[`PT_CNT_DW-1:0] | (cnt_t'(1) << `PT_MIN_WAIT_BIT);

endmodule

//--- ping_timer_pkg.sv
/*
 * alert ping timer package
 * FSM state and check-kind enums plus the vector and width types
 */
`include "ping_timer_config.svh"

package ping_timer_pkg;

  // plainly encoded ping FSM states
  typedef enum logic [2:0] {
    INIT,
    ALERT_WAIT,
    ALERT_PING,
    ESC_WAIT,
    ESC_PING
  } state_e;

  // which side the current health check belongs to
  typedef enum logic {
    CHECK_ALERT,
    CHECK_ESC
  } check_e;

  typedef logic [`PT_CNT_DW-1:0]   cnt_t;
  typedef logic [`PT_N_ALERTS-1:0] alert_vec_t;
  typedef logic [`PT_N_ESC-1:0]    esc_vec_t;
  typedef logic [`PT_ID_DW-1:0]    alert_id_t;
  typedef logic [1:0]              esc_id_t;

endpackage

//--- ping_timer_config.svh
/*
 * alert ping timer configuration
 * channel counts, counter and LFSR widths, LFSR seed and feedback taps,
 * and the bit that sets the minimum pause between pings
 */
`ifndef PING_TIMER_CONFIG_SVH
`define PING_TIMER_CONFIG_SVH

// number of alert receivers and escalation senders under test
`define PT_N_ALERTS 6
`define PT_N_ESC 4

// pause and timeout counter width
`define PT_CNT_DW 8

// LFSR width, and the alert index width taken from its upper bits
`define PT_LFSR_DW 16
`define PT_ID_DW 3

// reset state must never be zero, or the LFSR locks up
`define PT_LFSR_SEED 16'hace1
// x^16 + x^14 + x^13 + x^11 + 1, maximal length in Galois form
`define PT_LFSR_TAPS 16'hb400

// forcing this bit keeps every pause at 4 cycles or more
`define PT_MIN_WAIT_BIT 2

`endif
